/* list.f */
logic/sspRegPkg.sv
logic/sspFramePkg.sv
logic/sspFifo.sv
logic/sspClkScaler.sv
logic/sspMasterCtrl.sv
logic/sspApbRegs.sv
logic/sspTop.sv
sim/sspClkGen.sv
sim/sspTb.sv

/* Makefile */
# Verilator build and run of the SSP master testbench

SIM      := verilator
SIMFLAGS := --binary --timing --assert -Wno-fatal
TOP      := sspTb
FILELIST := list.f
OBJDIR   := obj_dir
LOG      := sim.log
PASSMSG  := STATUS: PASS

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# Pass or fail comes from the log, not from the exit code of the binary
run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASSMSG)" $(LOG) && echo "run passed" || (echo "run failed" && exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* sim/sspTb.sv */
// Directed testbench of the SSP master: APB tasks, SPI slave model, compare tasks and timeout
`timescale 1ns/1ps

module sspTb import sspRegPkg::*, sspFramePkg::*; ();

  localparam int fifoDepth = 8;
  localparam int idlePollLimit = 1000;
  // Bit periods per test, loopback, slave, rate, FIFO
  localparam int bitsLoopback = 390;
  localparam int bitsSlave = 128;
  localparam int bitsRate = 32;
  localparam int bitsFifo = 72;
  // Largest cpsr x (1 + scr) used, 8 x 5
  localparam int maxBitCycles = 40;
  localparam int cycleLimit = (bitsLoopback + bitsSlave + bitsRate + bitsFifo) * maxBitCycles * 2;

  logic     pclk;
  logic     arstN;
  logic     pSel = 1'b0;
  logic     pEnable = 1'b0;
  logic     pWrite = 1'b0;
  regAddr_t pAddr = '0;
  sspWord_t pWData = '0;
  sspWord_t pRData;
  logic     sspRxd = 1'b0;
  logic     sspTxd;
  logic     sspClk;
  logic     sspFss;
  logic     sspIntr;
  logic     sspTxIntr;
  logic     sspRxIntr;
  logic     sspRorIntr;

  int      nChecks = 0;
  int      nErrors = 0;
  int      cycleCount = 0;
  intVec_t curImsc = '0;

  // Slave model and edge monitor state
  logic     slaveOn = 1'b0;
  logic     slaveSph = 1'b0;
  int       slaveBits = 8;
  sspWord_t slaveReply = '0;
  sspWord_t slaveRx = '0;
  sspWord_t replyQ [$];
  sspWord_t seenQ [$];
  int       intervalQ [$];
  int       edgeCnt = 0;
  int       rxBits = 0;
  int       strayEdges = 0;
  int       sinceEdge = 0;
  logic     preloaded = 1'b0;
  logic     firstEdgeWait = 1'b0;
  logic     firstOfBit;
  logic     measureOn = 1'b0;
  logic     prevClk = 1'b0;
  logic     prevFss = 1'b1;

  sspClkGen #(.periodNs(100), .resetCycles(16)) u_sspClkGen (.pclk, .arstN);

  sspTop #(.fifoDepth(fifoDepth)) u_sspTop (
    .pclk, .arstN, .pSel, .pEnable, .pWrite, .pAddr, .pWData, .pRData,
    .sspRxd, .sspTxd, .sspClk, .sspFss,
    .sspIntr, .sspTxIntr, .sspRxIntr, .sspRorIntr
  );

  // ------------------------------------------------------------
  // SPI slave model and sspClk interval monitor
  // ------------------------------------------------------------
  task automatic takeReply();
    if (replyQ.size() > 0) begin
      slaveReply = replyQ.pop_front();
    end else begin
      slaveReply = '0;
    end
  endtask

  always @(posedge pclk) begin
    #1;
    sinceEdge = sinceEdge + 1;
    if (prevFss && !sspFss) begin
      // Frame opens, SPH 0 needs the MSB before the first edge
      edgeCnt = 0;
      rxBits = 0;
      slaveRx = '0;
      firstEdgeWait = 1'b1;
      if (slaveOn && !slaveSph) begin
        if (!preloaded) begin
          takeReply();
        end
        preloaded = 1'b0;
        sspRxd = slaveReply[slaveBits - 1];
      end
    end else if (sspClk != prevClk) begin
      if (sspFss) begin
        if (slaveOn) begin
          strayEdges++;
        end
      end else begin
        if (measureOn && !firstEdgeWait) begin
          intervalQ.push_back(sinceEdge);
        end
        firstEdgeWait = 1'b0;
        if (slaveOn) begin
          firstOfBit = ((edgeCnt % 2) == 0);
          if (firstOfBit ^ slaveSph) begin
            // Sample edge, MSB arrives first
            slaveRx = {slaveRx[14:0], sspTxd};
            rxBits++;
            if (rxBits == slaveBits) begin
              seenQ.push_back(slaveRx);
              rxBits = 0;
              slaveRx = '0;
            end
          end else if (slaveSph) begin
            if (edgeCnt == 0) begin
              takeReply();
            end
            sspRxd = slaveReply[slaveBits - 1 - edgeCnt / 2];
          end else if (edgeCnt == 2 * slaveBits - 1) begin
            // Back to back word, next MSB goes out on the last edge
            preloaded = (replyQ.size() > 0);
            if (preloaded) begin
              takeReply();
              sspRxd = slaveReply[slaveBits - 1];
            end
          end else begin
            sspRxd = slaveReply[slaveBits - 1 - (edgeCnt + 1) / 2];
          end
        end
        edgeCnt = (edgeCnt + 1) % (2 * slaveBits);
      end
      sinceEdge = 0;
    end
    prevClk = sspClk;
    prevFss = sspFss;
  end

  // Run limit
  always @(posedge pclk) begin
    cycleCount++;
    if (cycleCount >= cycleLimit) begin
      $display("timeout, run exceeded %0d pclk cycles", cycleLimit);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // ------------------------------------------------------------
  // APB access and compare tasks
  // ------------------------------------------------------------
  task automatic apbWrite(input regAddr_t addr, input sspWord_t data);
    @(posedge pclk);
    #1;
    pSel = 1'b1;
    pWrite = 1'b1;
    pAddr = addr;
    pWData = data;
    @(posedge pclk);
    #1;
    pEnable = 1'b1;
    @(posedge pclk);
    #1;
    pSel = 1'b0;
    pEnable = 1'b0;
    pWrite = 1'b0;
  endtask

  task automatic apbRead(input regAddr_t addr, output sspWord_t data);
    @(posedge pclk);
    #1;
    pSel = 1'b1;
    pWrite = 1'b0;
    pAddr = addr;
    @(posedge pclk);
    #1;
    pEnable = 1'b1;
    // Mid access phase, well away from the pop edge
    #40;
    data = pRData;
    @(posedge pclk);
    #1;
    pSel = 1'b0;
    pEnable = 1'b0;
  endtask

  task automatic checkWord(input string name, input sspWord_t expVal, input sspWord_t actVal);
    nChecks++;
    if (actVal !== expVal) begin
      nErrors++;
      $display("error %s: expected 0x%h, actual 0x%h", name, expVal, actVal);
    end
  endtask

  task automatic checkStatus(input string name, input logic [4:0] expVal,
                             input logic [4:0] actVal);
    nChecks++;
    if (actVal !== expVal) begin
      nErrors++;
      $display("error %s: expected 0x%h, actual 0x%h", name, expVal, actVal);
    end
  endtask

  task automatic checkIntVec(input string name, input intVec_t expVal, input intVec_t actVal);
    nChecks++;
    if (actVal !== expVal) begin
      nErrors++;
      $display("error %s: expected 0x%h, actual 0x%h", name, expVal, actVal);
    end
  endtask

  task automatic checkCount(input string name, input int expVal, input int actVal);
    nChecks++;
    if (actVal !== expVal) begin
      nErrors++;
      $display("error %s: expected 0x%h, actual 0x%h", name, expVal, actVal);
    end
  endtask

  // Poll SR until BSY drops
  task automatic waitIdle();
    sspWord_t sr;
    int polls;
    polls = 0;
    do begin
      apbRead(addrSr, sr);
      polls++;
    end while (sr[srBsy] && polls < idlePollLimit);
    if (sr[srBsy]) begin
      nErrors++;
      $display("BSY still set after %0d status reads", polls);
    end
  endtask

  task automatic setFormat(input sspDss_t dss, input logic spo, input logic sph,
                           input sspScr_t scr);
    apbWrite(addrCr0, {scr, sph, spo, 2'b00, dss});
  endtask

  // RIS, MIS and the four interrupt pins against one raw vector
  task automatic checkIrq(input intVec_t expRis);
    sspWord_t rd;
    intVec_t expMis;
    expMis = expRis & curImsc;
    apbRead(addrRis, rd);
    checkIntVec("RIS", expRis, rd[3:0]);
    apbRead(addrMis, rd);
    checkIntVec("MIS", expMis, rd[3:0]);
    checkIntVec("interrupt pins", expMis, {sspTxIntr, sspRxIntr, 1'b0, sspRorIntr});
    checkCount("sspIntr", int'(|expMis), int'(sspIntr));
  endtask

  task automatic reportTest(input string name, input int errStart);
    $display("test %s finished with %0d errors", name, nErrors - errStart);
  endtask

  // ------------------------------------------------------------
  // Directed tests
  // ------------------------------------------------------------
  task automatic testRegisters();
    sspWord_t rd;
    int errStart;
    errStart = nErrors;
    apbRead(addrSr, rd);
    checkStatus("SR after reset", 5'b00011, rd[4:0]);
    checkCount("sspFss after reset", 1, int'(sspFss));
    // FRF and reserved bits drop out
    apbWrite(addrCr0, 16'hA5FF);
    apbRead(addrCr0, rd);
    checkWord("CR0", 16'hA5CF, rd);
    apbWrite(addrCr1, 16'hFFFD);
    apbRead(addrCr1, rd);
    checkWord("CR1", 16'h0001, rd);
    apbWrite(addrCpsr, 16'hFF37);
    apbRead(addrCpsr, rd);
    checkWord("CPSR", 16'h0036, rd);
    apbWrite(addrImsc, 16'hFFFF);
    apbRead(addrImsc, rd);
    checkWord("IMSC", 16'h000D, rd);
    apbWrite(addrCr1, 16'h0000);
    apbWrite(addrImsc, 16'h0000);
    reportTest("registers", errStart);
  endtask

  task automatic testLoopback();
    sspWord_t sent [3];
    sspWord_t rd;
    sspWord_t mask;
    int errStart;
    errStart = nErrors;
    apbWrite(addrCpsr, 16'd4);
    apbWrite(addrCr1, 16'h0003);
    for (int d = 3; d <= 15; d++) begin
      setFormat(sspDss_t'(d), 1'b0, d[0], 8'd0);
      mask = sspWord_t'((32'd1 << (d + 1)) - 1);
      for (int i = 0; i < 3; i++) begin
        sent[i] = sspWord_t'($urandom);
        apbWrite(addrDr, sent[i]);
      end
      waitIdle();
      for (int i = 0; i < 3; i++) begin
        apbRead(addrDr, rd);
        checkWord("DR loopback word", sent[i] & mask, rd);
      end
    end
    apbWrite(addrCr1, 16'h0000);
    reportTest("loopback", errStart);
  endtask

  task automatic testSlaveModes();
    sspWord_t sent [4];
    sspWord_t reply [4];
    sspWord_t rd;
    int errStart;
    errStart = nErrors;
    apbWrite(addrCpsr, 16'd4);
    apbWrite(addrCr1, 16'h0002);
    for (int m = 0; m < 4; m++) begin
      setFormat(4'd7, m[1], m[0], 8'd0);
      slaveSph = m[0];
      slaveBits = 8;
      seenQ.delete();
      replyQ.delete();
      preloaded = 1'b0;
      strayEdges = 0;
      // Let the idle clock settle to the new polarity
      repeat (2) @(posedge pclk);
      slaveOn = 1'b1;
      for (int i = 0; i < 4; i++) begin
        reply[i] = sspWord_t'($urandom) & 16'h00FF;
        replyQ.push_back(reply[i]);
      end
      for (int i = 0; i < 4; i++) begin
        sent[i] = sspWord_t'($urandom);
        apbWrite(addrDr, sent[i]);
      end
      waitIdle();
      slaveOn = 1'b0;
      checkCount("sspFss after BSY", 1, int'(sspFss));
      checkCount("sspClk idle level", m[1], int'(sspClk));
      checkCount("slave word count", 4, seenQ.size());
      checkCount("sspClk edges with sspFss high", 0, strayEdges);
      for (int i = 0; i < 4 && i < seenQ.size(); i++) begin
        checkWord("slave sspTxd word", sent[i] & 16'h00FF, seenQ[i]);
      end
      for (int i = 0; i < 4; i++) begin
        apbRead(addrDr, rd);
        checkWord("DR slave reply", reply[i], rd);
      end
    end
    apbWrite(addrCr1, 16'h0000);
    reportTest("slave modes", errStart);
  endtask

  task automatic testBitRate();
    sspCpsr_t cpsrList [4] = '{8'd2, 8'd4, 8'd6, 8'd8};
    sspScr_t  scrList [4] = '{8'd0, 8'd1, 8'd2, 8'd4};
    sspWord_t word;
    sspWord_t rd;
    int expHalf;
    int errStart;
    errStart = nErrors;
    apbWrite(addrCr1, 16'h0003);
    for (int p = 0; p < 4; p++) begin
      apbWrite(addrCpsr, {8'h00, cpsrList[p]});
      setFormat(4'd7, 1'b0, 1'b0, scrList[p]);
      intervalQ.delete();
      measureOn = 1'b1;
      word = sspWord_t'($urandom);
      apbWrite(addrDr, word);
      waitIdle();
      measureOn = 1'b0;
      expHalf = int'(cpsrList[p]) * (1 + int'(scrList[p])) / 2;
      // Sixteen edges in one 8 bit word
      checkCount("sspClk intervals", 15, intervalQ.size());
      foreach (intervalQ[i]) begin
        checkCount("pclk cycles per half bit", expHalf, intervalQ[i]);
      end
      apbRead(addrDr, rd);
      checkWord("DR rate word", word & 16'h00FF, rd);
    end
    apbWrite(addrCr1, 16'h0000);
    reportTest("bit rate", errStart);
  endtask

  task automatic testFifoIrq();
    sspWord_t sent [fifoDepth + 1];
    sspWord_t rd;
    intVec_t expRis;
    int errStart;
    errStart = nErrors;
    apbWrite(addrCpsr, 16'd4);
    setFormat(4'd7, 1'b0, 1'b0, 8'd0);
    // Loopback with the engine held off
    apbWrite(addrCr1, 16'h0001);
    curImsc = 4'hD;
    apbWrite(addrImsc, {12'h000, curImsc});
    for (int i = 0; i < fifoDepth; i++) begin
      sent[i] = sspWord_t'($urandom);
      apbWrite(addrDr, sent[i]);
      apbRead(addrSr, rd);
      checkStatus("SR while filling", {1'b1, 2'b00, (i + 1 < fifoDepth), 1'b0}, rd[4:0]);
      expRis = '0;
      expRis[intTx] = (i + 1 <= fifoDepth / 2);
      checkIrq(expRis);
    end
    apbWrite(addrCr1, 16'h0003);
    waitIdle();
    apbRead(addrSr, rd);
    checkStatus("SR receive full", 5'b01111, rd[4:0]);
    checkIrq(4'b1100);
    // One word more than the receive FIFO holds
    sent[fifoDepth] = sspWord_t'($urandom);
    apbWrite(addrDr, sent[fifoDepth]);
    waitIdle();
    checkIrq(4'b1101);
    curImsc = 4'h1;
    apbWrite(addrImsc, {12'h000, curImsc});
    checkIrq(4'b1101);
    curImsc = 4'h8;
    apbWrite(addrImsc, {12'h000, curImsc});
    checkIrq(4'b1101);
    curImsc = 4'hD;
    apbWrite(addrImsc, {12'h000, curImsc});
    apbWrite(addrIcr, 16'h0001);
    checkIrq(4'b1100);
    for (int i = 0; i < fifoDepth; i++) begin
      apbRead(addrDr, rd);
      checkWord("DR after overrun", sent[i] & 16'h00FF, rd);
      expRis = 4'b1000;
      expRis[intRx] = (fifoDepth - 1 - i >= fifoDepth / 2);
      checkIrq(expRis);
    end
    apbRead(addrDr, rd);
    checkWord("DR empty read", 16'h0000, rd);
    apbRead(addrSr, rd);
    checkStatus("SR drained", 5'b00011, rd[4:0]);
    curImsc = '0;
    apbWrite(addrImsc, 16'h0000);
    apbWrite(addrCr1, 16'h0000);
    reportTest("fifo and interrupts", errStart);
  endtask

  // ------------------------------------------------------------
  // Sequence
  // ------------------------------------------------------------
  initial begin
    void'($urandom(18));
    wait (arstN === 1'b1);
    testRegisters();
    testLoopback();
    testSlaveModes();
    testBitRate();
    testFifoIrq();
    $display("checks %0d, errors %0d", nChecks, nErrors);
    if (nErrors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* sim/sspClkGen.sv */
// Testbench clock and reset source for the SSP master, free running pclk and a held low arstN
`timescale 1ns/1ps

module sspClkGen #(
  parameter int periodNs    = 100,
  parameter int resetCycles = 16
) (
  output logic pclk,
  output logic arstN
);

  initial begin
    pclk = 1'b0;
    forever #(periodNs / 2) pclk = ~pclk;
  end

  // Release just after an edge so no flop sees it mid update
  initial begin
    arstN = 1'b0;
    repeat (resetCycles) @(posedge pclk);
    #1 arstN = 1'b1;
  end

endmodule

/* logic/sspTop.sv */
// Top level of the SSP master, connects the APB registers, both FIFOs, the prescaler and the frame engine
`timescale 1ns/1ps

module sspTop import sspRegPkg::*, sspFramePkg::*; #(
  parameter int fifoDepth = 8
) (
  input  logic     pclk,
  input  logic     arstN,
  input  logic     pSel,
  input  logic     pEnable,
  input  logic     pWrite,
  input  regAddr_t pAddr,
  input  sspWord_t pWData,
  output sspWord_t pRData,
  input  logic     sspRxd,
  output logic     sspTxd,
  output logic     sspClk,
  output logic     sspFss,
  output logic     sspIntr,
  output logic     sspTxIntr,
  output logic     sspRxIntr,
  output logic     sspRorIntr
);

  // ------------------------------------------------------------
  // Interconnect
  // ------------------------------------------------------------
  logic [$clog2(fifoDepth):0] txLevel;
  logic [$clog2(fifoDepth):0] rxLevel;
  logic     txPush;
  logic     txPop;
  logic     txFull;
  logic     txEmpty;
  sspWord_t txWData;
  sspWord_t txRData;
  logic     rxPush;
  logic     rxPop;
  logic     rxFull;
  logic     rxEmpty;
  logic     rxOverflow;
  sspWord_t rxWData;
  sspWord_t rxRData;
  logic     busy;
  sspDss_t  dss;
  logic     spo;
  logic     sph;
  sspScr_t  scr;
  sspCpsr_t cpsr;
  logic     lbm;
  logic     sse;
  logic     scalerRun;
  logic     halfTick;

  // Register block and interrupt outputs
  sspApbRegs #(.fifoDepth(fifoDepth)) u_sspApbRegs (
    .pclk, .arstN, .pSel, .pEnable, .pWrite, .pAddr, .pWData, .pRData,
    .txLevel, .rxLevel, .txFull, .txEmpty, .rxFull, .rxEmpty, .rxOverflow,
    .rxRData, .busy, .txPush, .txWData, .rxPop,
    .dss, .spo, .sph, .scr, .cpsr, .lbm, .sse,
    .sspIntr, .sspTxIntr, .sspRxIntr, .sspRorIntr
  );

  // Transmit FIFO, overflow not needed since full drops are silent
  sspFifo #(.fifoDepth(fifoDepth)) txFifo (
    .pclk, .arstN, .push(txPush), .wData(txWData), .pop(txPop), .rData(txRData),
    .empty(txEmpty), .full(txFull), .level(txLevel), .overflow()
  );

  // Receive FIFO, overflow feeds the overrun status
  sspFifo #(.fifoDepth(fifoDepth)) rxFifo (
    .pclk, .arstN, .push(rxPush), .wData(rxWData), .pop(rxPop), .rData(rxRData),
    .empty(rxEmpty), .full(rxFull), .level(rxLevel), .overflow(rxOverflow)
  );

  sspClkScaler u_sspClkScaler (
    .pclk, .arstN, .scalerRun, .cpsr, .scr, .halfTick
  );

  // Frame engine and serial pins
  sspMasterCtrl u_sspMasterCtrl (
    .pclk, .arstN, .sse, .lbm, .spo, .sph, .dss, .txEmpty, .txRData, .txPop,
    .rxWData, .rxPush, .halfTick, .scalerRun, .busy,
    .sspRxd, .sspTxd, .sspClk, .sspFss
  );

endmodule

/* logic/sspApbRegs.sv */
// APB register block of the SSP: decode, control registers, status and interrupts
`timescale 1ns/1ps

module sspApbRegs import sspRegPkg::*, sspFramePkg::*; #(
  parameter int fifoDepth = 8
) (
  input  logic                       pclk,
  input  logic                       arstN,
  input  logic                       pSel,
  input  logic                       pEnable,
  input  logic                       pWrite,
  input  regAddr_t                   pAddr,
  input  sspWord_t                   pWData,
  output sspWord_t                   pRData,
  input  logic [$clog2(fifoDepth):0] txLevel,
  input  logic [$clog2(fifoDepth):0] rxLevel,
  input  logic                       txFull,
  input  logic                       txEmpty,
  input  logic                       rxFull,
  input  logic                       rxEmpty,
  input  logic                       rxOverflow,
  input  sspWord_t                   rxRData,
  input  logic                       busy,
  output logic                       txPush,
  output sspWord_t                   txWData,
  output logic                       rxPop,
  output sspDss_t                    dss,
  output logic                       spo,
  output logic                       sph,
  output sspScr_t                    scr,
  output sspCpsr_t                   cpsr,
  output logic                       lbm,
  output logic                       sse,
  output logic                       sspIntr,
  output logic                       sspTxIntr,
  output logic                       sspRxIntr,
  output logic                       sspRorIntr
);

  localparam int halfDepth = fifoDepth / 2;

  logic       wrEn;
  logic       rdEn;
  logic [6:0] cpsrHi;
  intVec_t    imsc;
  intVec_t    ris;
  intVec_t    mis;
  logic       rorRaw;
  logic [4:0] srVal;

  // Access phase qualifiers, no wait states
  assign wrEn = pSel && pEnable && pWrite;
  assign rdEn = pSel && pEnable && !pWrite;

  // ------------------------------------------------------------
  // FIFO side
  // ------------------------------------------------------------
  // Full TX FIFO drops the word itself
  assign txPush  = wrEn && (pAddr == addrDr);
  assign txWData = pWData;
  // Empty RX FIFO read pops nothing
  assign rxPop   = rdEn && (pAddr == addrDr) && !rxEmpty;

  // ------------------------------------------------------------
  // Control registers
  // ------------------------------------------------------------
  always_ff @(posedge pclk or negedge arstN) begin
    if (!arstN) begin
      dss    <= '0;
      spo    <= 1'b0;
      sph    <= 1'b0;
      scr    <= '0;
      lbm    <= 1'b0;
      sse    <= 1'b0;
      // Smallest legal divisor
      cpsrHi <= 7'd1;
      imsc   <= '0;
    end else if (wrEn) begin
      case (pAddr)
        addrCr0: begin
          dss <= pWData[cr0DssMsb:cr0DssLsb];
          spo <= pWData[cr0Spo];
          sph <= pWData[cr0Sph];
          scr <= pWData[cr0ScrMsb:cr0ScrLsb];
        end
        addrCr1: begin
          lbm <= pWData[cr1Lbm];
          sse <= pWData[cr1Sse];
        end
        addrCpsr: cpsrHi <= pWData[7:1];
        // Reserved bit 1 masked off
        addrImsc: imsc <= pWData[3:0] & 4'b1101;
        default: ;
      endcase
    end
  end

  assign cpsr = {cpsrHi, 1'b0};

  // ------------------------------------------------------------
  // Interrupts
  // ------------------------------------------------------------
  // Overrun sticks until ICR bit 0, a new overrun wins
  always_ff @(posedge pclk or negedge arstN) begin
    if (!arstN) begin
      rorRaw <= 1'b0;
    end else if (rxOverflow) begin
      rorRaw <= 1'b1;
    end else if (wrEn && (pAddr == addrIcr) && pWData[intRor]) begin
      rorRaw <= 1'b0;
    end
  end

  always_comb begin
    ris         = '0;
    ris[intRor] = rorRaw;
    // Half empty and half full thresholds
    ris[intRx]  = (rxLevel >= halfDepth);
    ris[intTx]  = (txLevel <= halfDepth);
  end

  assign mis        = ris & imsc;
  assign sspRorIntr = mis[intRor];
  assign sspRxIntr  = mis[intRx];
  assign sspTxIntr  = mis[intTx];
  assign sspIntr    = |mis;

  // ------------------------------------------------------------
  // Status and read mux
  // ------------------------------------------------------------
  always_comb begin
    srVal        = '0;
    srVal[srTfe] = txEmpty;
    srVal[srTnf] = !txFull;
    srVal[srRne] = !rxEmpty;
    srVal[srRff] = rxFull;
    srVal[srBsy] = busy;
  end

  always_comb begin
    pRData = '0;
    if (pSel && !pWrite) begin
      case (pAddr)
        addrCr0:  pRData = {scr, sph, spo, 2'b00, dss};
        addrCr1:  pRData = {14'b0, sse, lbm};
        addrDr:   pRData = rxEmpty ? '0 : rxRData;
        addrSr:   pRData = {11'b0, srVal};
        addrCpsr: pRData = {8'b0, cpsr};
        addrImsc: pRData = {12'b0, imsc};
        addrRis:  pRData = {12'b0, ris};
        addrMis:  pRData = {12'b0, mis};
        default:  pRData = '0;
      endcase
    end
  end

  // APB master must open every transfer with a setup phase
  apbEnableNeedsSel: assert property (@(posedge pclk) disable iff (!arstN)
    pEnable |-> pSel);

endmodule

/* logic/sspMasterCtrl.sv */
// SPI master frame engine, moves words from the transmit FIFO over the serial pins to the receive FIFO
`timescale 1ns/1ps

module sspMasterCtrl import sspFramePkg::*; (
  input  logic     pclk,
  input  logic     arstN,
  input  logic     sse,
  input  logic     lbm,
  input  logic     spo,
  input  logic     sph,
  input  sspDss_t  dss,
  input  logic     txEmpty,
  input  sspWord_t txRData,
  output logic     txPop,
  output sspWord_t rxWData,
  output logic     rxPush,
  input  logic     halfTick,
  output logic     scalerRun,
  output logic     busy,
  input  logic     sspRxd,
  output logic     sspTxd,
  output logic     sspClk,
  output logic     sspFss
);

  frameState_t state;
  frameState_t stateNext;
  sspWord_t    txShift;
  sspWord_t    rxShift;
  logic [4:0]  halfCnt;
  logic        wordReady;
  logic        firstEdge;
  logic        sampleEdge;
  logic        driveEdge;
  logic        lastTick;
  logic        rxIn;

  // ------------------------------------------------------------
  // Edge selection
  // ------------------------------------------------------------
  assign wordReady  = sse && !txEmpty;
  // Even half count means the first clock edge of a bit
  assign firstEdge  = !halfCnt[0];
  // SPH 0 samples on the first edge, SPH 1 on the second
  assign sampleEdge = halfTick && (firstEdge ^ sph);
  assign driveEdge  = halfTick && !(firstEdge ^ sph);
  // 2 x (dss + 1) half periods per word
  assign lastTick   = halfTick && (halfCnt == {dss, 1'b1});
  // Loopback takes the own transmit line
  assign rxIn       = lbm ? sspTxd : sspRxd;

  // ------------------------------------------------------------
  // Frame FSM
  // ------------------------------------------------------------
  always_comb begin
    stateNext = state;
    case (state)
      stIdle: begin
        if (wordReady) begin
          stateNext = stLoad;
        end
      end
      stLoad:  stateNext = stShift;
      stShift: begin
        if (lastTick) begin
          stateNext = stStore;
        end
      end
      // Back to back words keep the frame open
      stStore: stateNext = wordReady ? stLoad : stIdle;
      default: stateNext = stIdle;
    endcase
  end

  assign txPop     = (state == stLoad);
  assign rxPush    = (state == stStore);
  assign rxWData   = rxShift;
  assign scalerRun = (state == stShift);
  assign busy      = !txEmpty || (state != stIdle);

  // Control state and serial pins
  always_ff @(posedge pclk or negedge arstN) begin
    if (!arstN) begin
      state   <= stIdle;
      halfCnt <= '0;
      sspClk  <= 1'b0;
      sspFss  <= 1'b1;
      sspTxd  <= 1'b0;
    end else begin
      state <= stateNext;
      case (state)
        // Idle clock level follows polarity
        stIdle: sspClk <= spo;
        stLoad: begin
          halfCnt <= '0;
          sspFss  <= 1'b0;
          // SPH 0 puts the MSB out before the first edge
          if (!sph) begin
            sspTxd <= txRData[dss];
          end
        end
        stShift: begin
          if (halfTick) begin
            halfCnt <= halfCnt + 1'b1;
            sspClk  <= !sspClk;
          end
          if (driveEdge) begin
            sspTxd <= txShift[dss];
          end
        end
        stStore: begin
          if (!wordReady) begin
            sspFss <= 1'b1;
          end
        end
        default: ;
      endcase
    end
  end

  // ------------------------------------------------------------
  // Shift registers
  // ------------------------------------------------------------
  // Tx is read at bit dss, Rx fills from bit 0 so the word lands right justified
  always_ff @(posedge pclk) begin
    if (state == stLoad) begin
      txShift <= sph ? txRData : {txRData[14:0], 1'b0};
      rxShift <= '0;
    end else begin
      if (driveEdge) begin
        txShift <= {txShift[14:0], 1'b0};
      end
      if (sampleEdge) begin
        rxShift <= {rxShift[14:0], rxIn};
      end
    end
  end

  // Load is entered only with a word waiting in the transmit FIFO
  txPopNotEmpty: assert property (@(posedge pclk) disable iff (!arstN)
    txPop |-> !txEmpty);

endmodule

/* logic/sspClkScaler.sv */
// Serial bit rate prescaler, gives the SSP frame engine one tick per half bit period
`timescale 1ns/1ps

module sspClkScaler import sspFramePkg::*; (
  input  logic     pclk,
  input  logic     arstN,
  input  logic     scalerRun,
  input  sspCpsr_t cpsr,
  input  sspScr_t  scr,
  output logic     halfTick
);

  logic [6:0] preCnt;
  sspScr_t    rateCnt;
  logic       preCarry;
  logic       rateWrap;

  // ------------------------------------------------------------
  // Two stage divide, cpsr/2 then 1 + scr
  // ------------------------------------------------------------
  assign preCarry = scalerRun && (preCnt == cpsr[7:1] - 7'd1);
  assign rateWrap = (rateCnt == scr);
  // End of a half period
  assign halfTick = preCarry && rateWrap;

  always_ff @(posedge pclk or negedge arstN) begin
    if (!arstN) begin
      preCnt  <= '0;
      rateCnt <= '0;
    end else if (!scalerRun) begin
      // Restart so the first half period is full length
      preCnt  <= '0;
      rateCnt <= '0;
    end else if (preCarry) begin
      preCnt  <= '0;
      rateCnt <= rateWrap ? '0 : rateCnt + 1'b1;
    end else begin
      preCnt <= preCnt + 1'b1;
    end
  end

  // Register block must never hand over a zero or odd divisor
  scalerCpsrLegal: assert property (@(posedge pclk) disable iff (!arstN)
    scalerRun |-> ((cpsr != '0) && !cpsr[0]));

endmodule

/* logic/sspFifo.sv */
// Synchronous word FIFO with level count, instantiated for the SSP transmit and receive paths
`timescale 1ns/1ps

module sspFifo import sspFramePkg::*; #(
  parameter int fifoDepth = 8
) (
  input  logic                       pclk,
  input  logic                       arstN,
  input  logic                       push,
  input  sspWord_t                   wData,
  input  logic                       pop,
  output sspWord_t                   rData,
  output logic                       empty,
  output logic                       full,
  output logic [$clog2(fifoDepth):0] level,
  output logic                       overflow
);

  localparam int ptrW = $clog2(fifoDepth);

  sspWord_t        mem [fifoDepth];
  logic [ptrW-1:0] wrPtr;
  logic [ptrW-1:0] rdPtr;
  logic            doPush;
  logic            doPop;

  assign empty = (level == 0);
  assign full  = (level == fifoDepth);

  // ------------------------------------------------------------
  // Accept rules
  // ------------------------------------------------------------
  // Pop and push together are both taken, even when full
  assign doPop    = pop && !empty;
  assign doPush   = push && (!full || doPop);
  // One cycle pulse for a lost word
  assign overflow = push && !doPush;

  // Head word valid while not empty
  assign rData = mem[rdPtr];

  // ------------------------------------------------------------
  // Pointers and level
  // ------------------------------------------------------------
  always_ff @(posedge pclk or negedge arstN) begin
    if (!arstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      level <= '0;
    end else begin
      // Power of two depth, pointers wrap naturally
      if (doPush) begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (doPop) begin
        rdPtr <= rdPtr + 1'b1;
      end
      if (doPush && !doPop) begin
        level <= level + 1'b1;
      end else if (doPop && !doPush) begin
        level <= level - 1'b1;
      end
    end
  end

  // Storage array
  always_ff @(posedge pclk) begin
    if (doPush) begin
      mem[wrPtr] <= wData;
    end
  end

  fifoLevelBound: assert property (@(posedge pclk) disable iff (!arstN)
    level <= fifoDepth);

endmodule

/* logic/sspFramePkg.sv */
// Serial frame types shared by the FIFOs, the frame engine and the register block
package sspFramePkg;

  // ------------------------------------------------------------
  // Data path widths
  // ------------------------------------------------------------
  // One transfer word as written or received
  typedef logic [15:0] sspWord_t;

  // Word length minus one, legal 3 to 15
  typedef logic [3:0] sspDss_t;

  // Serial clock rate, bit rate divides by 1 + scr
  typedef logic [7:0] sspScr_t;

  // Prescale divisor, even only, bit 0 reads zero
  typedef logic [7:0] sspCpsr_t;

  // ------------------------------------------------------------
  // Master frame engine states
  // ------------------------------------------------------------
  typedef enum logic [1:0] {
    stIdle,
    stLoad,
    stShift,
    stStore
  } frameState_t;

endpackage

/* logic/sspRegPkg.sv */
// Register map of the SSP APB port, imported by the register block and the top level
package sspRegPkg;

  // ------------------------------------------------------------
  // Word addresses, pAddr bits 11 to 2
  // ------------------------------------------------------------
  typedef logic [9:0] regAddr_t;

  localparam regAddr_t addrCr0  = 10'h000;
  localparam regAddr_t addrCr1  = 10'h001;
  localparam regAddr_t addrDr   = 10'h002;
  localparam regAddr_t addrSr   = 10'h003;
  localparam regAddr_t addrCpsr = 10'h004;
  localparam regAddr_t addrImsc = 10'h005;
  localparam regAddr_t addrRis  = 10'h006;
  localparam regAddr_t addrMis  = 10'h007;
  localparam regAddr_t addrIcr  = 10'h008;

  // ------------------------------------------------------------
  // Field positions
  // ------------------------------------------------------------
  // CR0, frame format bits 5:4 always read zero
  localparam int cr0DssLsb = 0;
  localparam int cr0DssMsb = 3;
  localparam int cr0Spo    = 6;
  localparam int cr0Sph    = 7;
  localparam int cr0ScrLsb = 8;
  localparam int cr0ScrMsb = 15;

  // CR1
  localparam int cr1Lbm = 0;
  localparam int cr1Sse = 1;

  // SR
  localparam int srTfe = 0;
  localparam int srTnf = 1;
  localparam int srRne = 2;
  localparam int srRff = 3;
  localparam int srBsy = 4;

  // IMSC, RIS, MIS and ICR, bit 1 reserved
  localparam int intRor = 0;
  localparam int intRx  = 2;
  localparam int intTx  = 3;

  typedef logic [3:0] intVec_t;

endpackage
